// File: logic/gbc_mem_pkg.sv
package gbc_mem_pkg;

   // the CPU side of the console is an 8-bit data bus on a 16-bit address space
   localparam int BUS_ADDR_W = 16;
   localparam int BUS_DATA_W = 8;

   typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
   typedef logic [BUS_DATA_W-1:0] bus_data_t;

   // colour palette registers in the I/O page
   localparam bus_addr_t BCPS_ADDR = 16'hFF68; // background palette specification
   localparam bus_addr_t BCPD_ADDR = 16'hFF69; // background palette data
   localparam bus_addr_t OCPS_ADDR = 16'hFF6A; // object palette specification
   localparam bus_addr_t OCPD_ADDR = 16'hFF6B; // object palette data

   // register code handed from the address decoder to the colour file
   typedef logic [1:0] reg_sel_t;

   localparam reg_sel_t REG_BCPS = 2'd0;
   localparam reg_sel_t REG_BCPD = 2'd1;
   localparam reg_sel_t REG_OCPS = 2'd2;
   localparam reg_sel_t REG_OCPD = 2'd3;

   // bit positions inside a specification register
   localparam int SPEC_INC_BIT = 7;
   localparam int SPEC_ZERO_BIT = 6; // this bit is stored but always reads back as 0

endpackage

// File: logic/gbc_video_pkg.sv
package gbc_video_pkg;

   // palette geometry, identical for the background and the sprite side
   localparam int PAL_COUNT = 8;
   localparam int PAL_COLORS = 4;
   localparam int COLOR_BYTES = 2;
   localparam int PAL_BYTES = PAL_COUNT * PAL_COLORS * COLOR_BYTES;

   typedef logic [$clog2(PAL_COUNT)-1:0]  pal_sel_t;
   typedef logic [$clog2(PAL_COLORS)-1:0] pal_index_t;
   typedef logic [$clog2(PAL_BYTES)-1:0]  pal_addr_t;

   // a stored colour is 15 bits of BGR, the top bit of the high byte is ignored
   typedef logic [15:0] color_t;

   localparam int CHAN_W = 5;
   localparam int RED_LSB = 0;
   localparam int GREEN_LSB = 5;
   localparam int BLUE_LSB = 10;

   typedef logic [CHAN_W-1:0] chan_t;

   // output pixels are 8 bits per channel with red in the top byte
   localparam int RGB_CHAN_W = 8;

   typedef logic [RGB_CHAN_W-1:0]   rgb_chan_t;
   typedef logic [3*RGB_CHAN_W-1:0] rgb_t;

endpackage

// File: logic/io_reg_router.sv
module io_reg_router (
   input  logic                   I_CLK,
   input  logic                   arst_n,

   // CPU bus with active-low control
   input  gbc_mem_pkg::bus_addr_t addr,
   input  logic                   we_n,
   input  logic                   re_n,

   // towards the colour file
   output logic                   reg_wr,
   output gbc_mem_pkg::reg_sel_t  reg_sel,
   input  gbc_mem_pkg::bus_data_t reg_rdata,

   // registered read return
   output gbc_mem_pkg::bus_data_t rdata,
   output logic                   rd_valid
);

   logic hit;    // address is one of the four palette registers
   logic rd_hit;

   // all address decoding for the palette block lives here
   always_comb begin
      hit = 1'b1;
      reg_sel = gbc_mem_pkg::REG_BCPS;
      case (addr)
         gbc_mem_pkg::BCPS_ADDR: begin
            reg_sel = gbc_mem_pkg::REG_BCPS;
         end
         gbc_mem_pkg::BCPD_ADDR: begin
            reg_sel = gbc_mem_pkg::REG_BCPD;
         end
         gbc_mem_pkg::OCPS_ADDR: begin
            reg_sel = gbc_mem_pkg::REG_OCPS;
         end
         gbc_mem_pkg::OCPD_ADDR: begin
            reg_sel = gbc_mem_pkg::REG_OCPD;
         end
         default: begin
            hit = 1'b0; // reg_sel keeps its default and nothing acts on it
         end
      endcase
   end

   // each edge with we_n low is exactly one write, so the level is the strobe
   assign reg_wr = hit && !we_n;
   assign rd_hit = hit && !re_n;

   always_ff @(posedge I_CLK or negedge arst_n) begin
      if (!arst_n) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_hit; // one cycle per read edge
      end
   end

   // the colour file answer is captured on the read edge
   always_ff @(posedge I_CLK) begin
      if (rd_hit) begin
         rdata <= reg_rdata;
      end
   end

endmodule

// File: logic/color_file.sv
module color_file (
   input  logic                      I_CLK,
   input  logic                      arst_n,

   // register access from the bus decoder
   input  logic                      reg_wr,
   input  gbc_mem_pkg::reg_sel_t     reg_sel,
   input  gbc_mem_pkg::bus_data_t    wdata,
   output gbc_mem_pkg::bus_data_t    reg_rdata,

   // background colour lookup
   input  gbc_video_pkg::pal_sel_t   bg_pal,
   input  gbc_video_pkg::pal_index_t bg_index,
   output gbc_video_pkg::color_t     bg_color,

   // sprite colour lookup
   input  gbc_video_pkg::pal_sel_t   spr_pal,
   input  gbc_video_pkg::pal_index_t spr_index,
   output gbc_video_pkg::color_t     spr_color
);

   // 8 palettes of 4 colours of 2 bytes on each side
   gbc_mem_pkg::bus_data_t bg_mem  [gbc_video_pkg::PAL_BYTES];
   gbc_mem_pkg::bus_data_t spr_mem [gbc_video_pkg::PAL_BYTES];

   // specification registers keep the whole written byte
   gbc_mem_pkg::bus_data_t bcps_q;
   gbc_mem_pkg::bus_data_t ocps_q;

   gbc_video_pkg::pal_addr_t bg_ptr;
   gbc_video_pkg::pal_addr_t spr_ptr;
   logic                     bg_inc;
   logic                     spr_inc;

   logic bg_data_wr;
   logic spr_data_wr;

   gbc_mem_pkg::bus_data_t bcps_rd;
   gbc_mem_pkg::bus_data_t ocps_rd;

   gbc_video_pkg::pal_addr_t bg_lo_addr;
   gbc_video_pkg::pal_addr_t bg_hi_addr;
   gbc_video_pkg::pal_addr_t spr_lo_addr;
   gbc_video_pkg::pal_addr_t spr_hi_addr;

   assign bg_ptr = bcps_q[5:0];
   assign spr_ptr = ocps_q[5:0];
   assign bg_inc = bcps_q[gbc_mem_pkg::SPEC_INC_BIT];
   assign spr_inc = ocps_q[gbc_mem_pkg::SPEC_INC_BIT];

   assign bg_data_wr = reg_wr && (reg_sel == gbc_mem_pkg::REG_BCPD);
   assign spr_data_wr = reg_wr && (reg_sel == gbc_mem_pkg::REG_OCPD);

   always_ff @(posedge I_CLK or negedge arst_n) begin
      if (!arst_n) begin
         bcps_q <= '0;
         ocps_q <= '0;
      end else if (reg_wr) begin
         case (reg_sel)
            gbc_mem_pkg::REG_BCPS: begin
               bcps_q <= wdata;
            end
            gbc_mem_pkg::REG_BCPD: begin
               // the 6-bit index rolls over from 63 to 0 by itself
               if (bg_inc) begin
                  bcps_q[5:0] <= bg_ptr + 1'b1;
               end
            end
            gbc_mem_pkg::REG_OCPS: begin
               ocps_q <= wdata;
            end
            default: begin // REG_OCPD
               if (spr_inc) begin
                  ocps_q[5:0] <= spr_ptr + 1'b1;
               end
            end
         endcase
      end
   end

   // a data write stores the byte at the current index
   always_ff @(posedge I_CLK) begin
      if (bg_data_wr) begin
         bg_mem[bg_ptr] <= wdata;
      end
      if (spr_data_wr) begin
         spr_mem[spr_ptr] <= wdata;
      end
   end

   // bit 6 of a specification register always reads as 0
   always_comb begin
      bcps_rd = bcps_q;
      ocps_rd = ocps_q;
      bcps_rd[gbc_mem_pkg::SPEC_ZERO_BIT] = 1'b0;
      ocps_rd[gbc_mem_pkg::SPEC_ZERO_BIT] = 1'b0;
   end

   // a data read never moves the index
   always_comb begin
      case (reg_sel)
         gbc_mem_pkg::REG_BCPS: reg_rdata = bcps_rd;
         gbc_mem_pkg::REG_BCPD: reg_rdata = bg_mem[bg_ptr];
         gbc_mem_pkg::REG_OCPS: reg_rdata = ocps_rd;
         default:               reg_rdata = spr_mem[spr_ptr];
      endcase
   end

   // on the picture side colour i of a palette sits at bytes 2i and 2i+1
   assign bg_lo_addr = {bg_pal, bg_index, 1'b0};
   assign bg_hi_addr = {bg_pal, bg_index, 1'b1};
   assign spr_lo_addr = {spr_pal, spr_index, 1'b0};
   assign spr_hi_addr = {spr_pal, spr_index, 1'b1};

   assign bg_color = {bg_mem[bg_hi_addr], bg_mem[bg_lo_addr]};    // even byte is the low half
   assign spr_color = {spr_mem[spr_hi_addr], spr_mem[spr_lo_addr]};

endmodule

// File: logic/pixel_color_out.sv
module pixel_color_out (
   input  logic                      I_CLK,
   input  logic                      arst_n,

   // incoming pixel pair
   input  logic                      pix_valid,
   input  gbc_video_pkg::pal_sel_t   bg_pal_in,
   input  gbc_video_pkg::pal_sel_t   spr_pal_in,
   input  gbc_video_pkg::pal_index_t bg_index_in,
   input  gbc_video_pkg::pal_index_t spr_index_in,
   input  logic                      spr_present,

   // colour file lookups, answered in the same cycle
   output gbc_video_pkg::pal_sel_t   bg_pal,
   output gbc_video_pkg::pal_index_t bg_index,
   output gbc_video_pkg::pal_sel_t   spr_pal,
   output gbc_video_pkg::pal_index_t spr_index,
   input  gbc_video_pkg::color_t     bg_color,
   input  gbc_video_pkg::color_t     spr_color,

   output gbc_video_pkg::rgb_t       rgb,
   output logic                      rgb_valid
);

   logic                      s1_valid;
   gbc_video_pkg::pal_sel_t   s1_bg_pal;
   gbc_video_pkg::pal_sel_t   s1_spr_pal;
   gbc_video_pkg::pal_index_t s1_bg_index;
   gbc_video_pkg::pal_index_t s1_spr_index;
   logic                      s1_spr_present;

   logic                  spr_wins;
   gbc_video_pkg::color_t win_color;

   // 5-bit channel goes to the top, its upper bits refill the bottom
   function automatic gbc_video_pkg::rgb_chan_t widen(input gbc_video_pkg::chan_t c);
      return {c, c[gbc_video_pkg::CHAN_W-1 -: gbc_video_pkg::RGB_CHAN_W - gbc_video_pkg::CHAN_W]};
   endfunction

   function automatic gbc_video_pkg::rgb_t expand(input gbc_video_pkg::color_t col);
      gbc_video_pkg::chan_t r;
      gbc_video_pkg::chan_t g;
      gbc_video_pkg::chan_t b;
      r = col[gbc_video_pkg::RED_LSB +: gbc_video_pkg::CHAN_W];
      g = col[gbc_video_pkg::GREEN_LSB +: gbc_video_pkg::CHAN_W];
      b = col[gbc_video_pkg::BLUE_LSB +: gbc_video_pkg::CHAN_W];
      return {widen(r), widen(g), widen(b)}; // bit 15 drops out here
   endfunction

   // stage 1 holds the pixel while the colour file is looked up
   always_ff @(posedge I_CLK or negedge arst_n) begin
      if (!arst_n) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= pix_valid;
      end
   end

   always_ff @(posedge I_CLK) begin
      s1_bg_pal <= bg_pal_in;
      s1_spr_pal <= spr_pal_in;
      s1_bg_index <= bg_index_in;
      s1_spr_index <= spr_index_in;
      s1_spr_present <= spr_present;
   end

   assign bg_pal = s1_bg_pal;
   assign bg_index = s1_bg_index;
   assign spr_pal = s1_spr_pal;
   assign spr_index = s1_spr_index;

   // colour 0 of a sprite is transparent
   assign spr_wins = s1_spr_present && (s1_spr_index != '0);
   assign win_color = spr_wins ? spr_color : bg_color;

   // stage 2
   always_ff @(posedge I_CLK or negedge arst_n) begin
      if (!arst_n) begin
         rgb_valid <= 1'b0;
      end else begin
         rgb_valid <= s1_valid;
      end
   end

   always_ff @(posedge I_CLK) begin
      rgb <= expand(win_color);
   end

endmodule

// File: logic/palette_subsystem_top.sv
module palette_subsystem_top (
   input  logic                      I_CLK,
   input  logic                      arst_n,

   // CPU bus
   input  gbc_mem_pkg::bus_addr_t    addr,
   input  gbc_mem_pkg::bus_data_t    wdata,
   input  logic                      we_n,
   input  logic                      re_n,
   output gbc_mem_pkg::bus_data_t    rdata,
   output logic                      rd_valid,

   // pixel stream in and out
   input  logic                      pix_valid,
   input  gbc_video_pkg::pal_sel_t   bg_pal_in,
   input  gbc_video_pkg::pal_index_t bg_index_in,
   input  gbc_video_pkg::pal_sel_t   spr_pal_in,
   input  gbc_video_pkg::pal_index_t spr_index_in,
   input  logic                      spr_present,
   output gbc_video_pkg::rgb_t       rgb,
   output logic                      rgb_valid
);

   logic                      reg_wr;
   gbc_mem_pkg::reg_sel_t     reg_sel;
   gbc_mem_pkg::bus_data_t    reg_rdata;

   gbc_video_pkg::pal_sel_t   bg_pal;
   gbc_video_pkg::pal_index_t bg_index;
   gbc_video_pkg::pal_sel_t   spr_pal;
   gbc_video_pkg::pal_index_t spr_index;
   gbc_video_pkg::color_t     bg_color;
   gbc_video_pkg::color_t     spr_color;

   io_reg_router i_router (
      .I_CLK     (I_CLK),
      .arst_n    (arst_n),
      .addr      (addr),
      .we_n      (we_n),
      .re_n      (re_n),
      .reg_wr    (reg_wr),
      .reg_sel   (reg_sel),
      .reg_rdata (reg_rdata),
      .rdata     (rdata),
      .rd_valid  (rd_valid)
   );

   // write data goes straight to the colour file, only the strobe is decoded
   color_file i_color_file (
      .I_CLK     (I_CLK),
      .arst_n    (arst_n),
      .reg_wr    (reg_wr),
      .reg_sel   (reg_sel),
      .wdata     (wdata),
      .reg_rdata (reg_rdata),
      .bg_pal    (bg_pal),
      .bg_index  (bg_index),
      .bg_color  (bg_color),
      .spr_pal   (spr_pal),
      .spr_index (spr_index),
      .spr_color (spr_color)
   );

   pixel_color_out i_pixel_out (
      .I_CLK        (I_CLK),
      .arst_n       (arst_n),
      .pix_valid    (pix_valid),
      .bg_pal_in    (bg_pal_in),
      .spr_pal_in   (spr_pal_in),
      .bg_index_in  (bg_index_in),
      .spr_index_in (spr_index_in),
      .spr_present  (spr_present),
      .bg_pal       (bg_pal),
      .bg_index     (bg_index),
      .spr_pal      (spr_pal),
      .spr_index    (spr_index),
      .bg_color     (bg_color),
      .spr_color    (spr_color),
      .rgb          (rgb),
      .rgb_valid    (rgb_valid)
   );

endmodule

// File: tb/tb_palette_top.sv
module tb_palette_top;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 4;
   localparam int RESET_CYCLES = 16;
   // reset regs, fill and readback, overwrite, pixels, sprite mix, rewrite
   localparam int TEST_CYCLES = 20 + 540 + 30 + 60 + 80 + 30;
   localparam int MARGIN_CYCLES = 300;

   logic                   I_CLK = 1'b0;
   logic                   arst_n;
   gbc_mem_pkg::bus_addr_t addr;
   gbc_mem_pkg::bus_data_t wdata;
   gbc_mem_pkg::bus_data_t rdata;
   logic                   we_n;
   logic                   re_n;
   logic                   rd_valid;
   logic                   pix_valid;
   logic [2:0]             bg_pal_in;
   logic [1:0]             bg_index_in;
   logic [2:0]             spr_pal_in;
   logic [1:0]             spr_index_in;
   logic                   spr_present;
   logic [23:0]            rgb;
   logic                   rgb_valid;

   logic [7:0]  ref_bg [64]; // model of the background palette bytes
   logic [7:0]  ref_spr [64];
   logic [7:0]  ref_bcps;
   logic [7:0]  ref_ocps;
   logic [7:0]  exp_rd_val [$];
   int          exp_rd_due [$]; // cycle in which rd_valid must show
   logic [23:0] exp_rgb_val [$];
   int          exp_rgb_due [$];

   integer seed;
   int     cyc = 0;
   string  cur_test;
   int     test_errs;
   int     err_total = 0;
   int     tests_run = 0;
   int     tests_failed = 0;
   int     checks = 0;

   palette_subsystem_top i_dut (
      .I_CLK(I_CLK), .arst_n(arst_n), .addr(addr), .wdata(wdata), .we_n(we_n),
      .re_n(re_n), .rdata(rdata), .rd_valid(rd_valid), .pix_valid(pix_valid),
      .bg_pal_in(bg_pal_in), .bg_index_in(bg_index_in), .spr_pal_in(spr_pal_in),
      .spr_index_in(spr_index_in), .spr_present(spr_present), .rgb(rgb),
      .rgb_valid(rgb_valid)
   );

   always #(CLK_PERIOD / 2) I_CLK = ~I_CLK;

   always @(posedge I_CLK) cyc <= cyc + 1;

   function automatic logic [7:0] rand8();
      logic [31:0] r;
      r = $random(seed);
      return r[7:0];
   endfunction

   function automatic logic [7:0] ref_read(input logic [15:0] a);
      case (a)
         gbc_mem_pkg::BCPS_ADDR: ref_read = ref_bcps & 8'hBF; // bit 6 is never read back
         gbc_mem_pkg::BCPD_ADDR: ref_read = ref_bg[ref_bcps[5:0]];
         gbc_mem_pkg::OCPS_ADDR: ref_read = ref_ocps & 8'hBF;
         default:                ref_read = ref_spr[ref_ocps[5:0]];
      endcase
   endfunction

   function automatic logic [23:0] ref_rgb(input logic [2:0] bp, input logic [1:0] bi,
                                           input logic [2:0] sp, input logic [1:0] si,
                                           input logic pres);
      logic [15:0] c;
      if (pres && si != 2'd0) begin
         c = {ref_spr[{sp, si, 1'b1}], ref_spr[{sp, si, 1'b0}]};
      end else begin
         c = {ref_bg[{bp, bi, 1'b1}], ref_bg[{bp, bi, 1'b0}]};
      end
      // red goes to the top byte and each channel repeats its upper 3 bits below
      return {c[4:0], c[4:2], c[9:5], c[9:7], c[14:10], c[14:12]};
   endfunction

   task automatic flag(input string line);
      $display("%s", line);
      test_errs++;
      err_total++;
   endtask

   // registered outputs are sampled half a cycle after the edge that set them
   always @(negedge I_CLK) begin
      if (arst_n) begin
         if (exp_rd_due.size() != 0 && exp_rd_due[0] == cyc) begin
            checks++;
            if (rd_valid !== 1'b1) begin
               flag($sformatf("%s: a palette register read got no rd_valid", cur_test));
            end else if (rdata !== exp_rd_val[0]) begin
               flag($sformatf("Mismatch %s rdata: expected %h, actual %h",
                              cur_test, exp_rd_val[0], rdata));
            end
            void'(exp_rd_due.pop_front());
            void'(exp_rd_val.pop_front());
         end else if (rd_valid !== 1'b0) begin
            flag($sformatf("%s: rd_valid rose with no palette read pending", cur_test));
         end
         if (exp_rgb_due.size() != 0 && exp_rgb_due[0] == cyc) begin
            checks++;
            if (rgb_valid !== 1'b1) begin
               flag($sformatf("%s: a pixel got no rgb_valid two cycles later", cur_test));
            end else if (rgb !== exp_rgb_val[0]) begin
               flag($sformatf("Mismatch %s rgb: expected %h, actual %h",
                              cur_test, exp_rgb_val[0], rgb));
            end
            void'(exp_rgb_due.pop_front());
            void'(exp_rgb_val.pop_front());
         end else if (rgb_valid !== 1'b0) begin
            flag($sformatf("%s: rgb_valid rose with no pixel in flight", cur_test));
         end
      end
   end

   task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
      @(posedge I_CLK);
      #1;
      addr = a;
      wdata = d;
      we_n = 1'b0;
      re_n = 1'b1;
      pix_valid = 1'b0;
      case (a)
         gbc_mem_pkg::BCPS_ADDR: ref_bcps = d;
         gbc_mem_pkg::BCPD_ADDR: begin
            ref_bg[ref_bcps[5:0]] = d;
            if (ref_bcps[7]) begin
               ref_bcps[5:0] = ref_bcps[5:0] + 6'd1; // wraps from 63 to 0
            end
         end
         gbc_mem_pkg::OCPS_ADDR: ref_ocps = d;
         gbc_mem_pkg::OCPD_ADDR: begin
            ref_spr[ref_ocps[5:0]] = d;
            if (ref_ocps[7]) begin
               ref_ocps[5:0] = ref_ocps[5:0] + 6'd1;
            end
         end
         default: begin
         end
      endcase
   endtask

   task automatic bus_read(input logic [15:0] a);
      @(posedge I_CLK);
      #1;
      addr = a;
      we_n = 1'b1;
      re_n = 1'b0;
      pix_valid = 1'b0;
      if (a >= gbc_mem_pkg::BCPS_ADDR && a <= gbc_mem_pkg::OCPD_ADDR) begin
         exp_rd_val.push_back(ref_read(a));
         exp_rd_due.push_back(cyc + 1);
      end
   endtask

   task automatic send_pixel(input logic [2:0] bp, input logic [1:0] bi,
                             input logic [2:0] sp, input logic [1:0] si, input logic pres);
      @(posedge I_CLK);
      #1;
      we_n = 1'b1;
      re_n = 1'b1;
      pix_valid = 1'b1;
      bg_pal_in = bp;
      bg_index_in = bi;
      spr_pal_in = sp;
      spr_index_in = si;
      spr_present = pres;
      exp_rgb_val.push_back(ref_rgb(bp, bi, sp, si, pres));
      exp_rgb_due.push_back(cyc + 2);
   endtask

   task automatic send_rand_pixel(input logic allow_spr);
      logic [31:0] r;
      r = $random(seed);
      send_pixel(r[2:0], r[4:3], r[7:5], r[9:8], allow_spr & r[10]);
   endtask

   task automatic drain();
      @(posedge I_CLK);
      #1;
      we_n = 1'b1;
      re_n = 1'b1;
      pix_valid = 1'b0;
      while (exp_rd_due.size() != 0 || exp_rgb_due.size() != 0) begin
         @(posedge I_CLK);
      end
      @(posedge I_CLK);
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      drain();
      tests_run++;
      if (test_errs == 0) begin
         $display("test %s: ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", cur_test, test_errs);
      end
   endtask

   task automatic fill_side(input logic [15:0] spec, input logic [15:0] data);
      bus_write(spec, 8'h80);
      for (int i = 0; i < 64; i++) begin
         bus_write(data, rand8());
      end
      bus_read(spec); // 64 increments bring the index back to 0
   endtask

   task automatic check_side(input logic [15:0] spec, input logic [15:0] data);
      logic [7:0] idx;
      for (idx = 8'd0; idx < 8'd64; idx++) begin
         bus_write(spec, idx);
         bus_read(data);
         bus_read(data); // a second read must return the same byte
      end
      bus_read(spec);
   endtask

   initial begin
      seed = 32'ha0a7_dab9;
      arst_n = 1'b0;
      addr = '0;
      wdata = '0;
      we_n = 1'b1;
      re_n = 1'b1;
      pix_valid = 1'b0;
      bg_pal_in = '0;
      bg_index_in = '0;
      spr_pal_in = '0;
      spr_index_in = '0;
      spr_present = 1'b0;
      ref_bcps = '0;
      ref_ocps = '0;
      repeat (RESET_CYCLES) @(posedge I_CLK);
      #1;
      arst_n = 1'b1;

      begin_test("reset_values");
      bus_read(gbc_mem_pkg::BCPS_ADDR);
      bus_read(gbc_mem_pkg::OCPS_ADDR);
      bus_read(16'hFF6C); // neighbours of the palette block give no rd_valid
      bus_read(16'hFF67);
      end_test();

      begin_test("autoinc_fill");
      fill_side(gbc_mem_pkg::BCPS_ADDR, gbc_mem_pkg::BCPD_ADDR);
      fill_side(gbc_mem_pkg::OCPS_ADDR, gbc_mem_pkg::OCPD_ADDR);
      check_side(gbc_mem_pkg::BCPS_ADDR, gbc_mem_pkg::BCPD_ADDR);
      check_side(gbc_mem_pkg::OCPS_ADDR, gbc_mem_pkg::OCPD_ADDR);
      end_test();

      begin_test("overwrite_wrap");
      bus_write(gbc_mem_pkg::BCPS_ADDR, 8'h05);
      bus_write(gbc_mem_pkg::BCPD_ADDR, 8'h11);
      bus_write(gbc_mem_pkg::BCPD_ADDR, rand8());
      bus_read(gbc_mem_pkg::BCPD_ADDR);
      bus_read(gbc_mem_pkg::BCPS_ADDR);
      bus_write(gbc_mem_pkg::OCPS_ADDR, 8'h2A);
      bus_write(gbc_mem_pkg::OCPD_ADDR, 8'h3C);
      bus_write(gbc_mem_pkg::OCPD_ADDR, rand8());
      bus_read(gbc_mem_pkg::OCPD_ADDR);
      // index 63 with bit 6 set and auto-increment on
      bus_write(gbc_mem_pkg::BCPS_ADDR, 8'hFF);
      bus_read(gbc_mem_pkg::BCPS_ADDR);
      bus_write(gbc_mem_pkg::BCPD_ADDR, 8'h5A);
      bus_write(gbc_mem_pkg::BCPD_ADDR, 8'hA5);
      bus_read(gbc_mem_pkg::BCPS_ADDR);
      bus_write(gbc_mem_pkg::BCPS_ADDR, 8'h3F);
      bus_read(gbc_mem_pkg::BCPD_ADDR);
      bus_write(gbc_mem_pkg::BCPS_ADDR, 8'h00);
      bus_read(gbc_mem_pkg::BCPD_ADDR);
      end_test();

      begin_test("pixel_colors");
      repeat (32) send_rand_pixel(1'b0);
      send_pixel(3'd2, 2'd1, 3'd6, 2'd3, 1'b0);
      send_pixel(3'd2, 2'd1, 3'd6, 2'd3, 1'b1);
      drain();
      // flip bit 15 of background 2 colour 1 and sprite 6 colour 3
      bus_write(gbc_mem_pkg::BCPS_ADDR, 8'h13);
      bus_write(gbc_mem_pkg::BCPD_ADDR, ref_bg[19] ^ 8'h80);
      bus_write(gbc_mem_pkg::OCPS_ADDR, 8'h37);
      bus_write(gbc_mem_pkg::OCPD_ADDR, ref_spr[55] ^ 8'h80);
      send_pixel(3'd2, 2'd1, 3'd6, 2'd3, 1'b0);
      send_pixel(3'd2, 2'd1, 3'd6, 2'd3, 1'b1);
      end_test();

      begin_test("sprite_select");
      repeat (64) send_rand_pixel(1'b1);
      end_test();

      begin_test("palette_rewrite");
      send_pixel(3'd5, 2'd3, 3'd1, 2'd2, 1'b0);
      send_pixel(3'd5, 2'd3, 3'd1, 2'd2, 1'b1);
      bus_write(gbc_mem_pkg::BCPS_ADDR, 8'hAE); // background 5 colour 3 with auto-increment
      bus_write(gbc_mem_pkg::BCPD_ADDR, rand8());
      bus_write(gbc_mem_pkg::BCPD_ADDR, rand8());
      bus_write(gbc_mem_pkg::OCPS_ADDR, 8'h8C);
      bus_write(gbc_mem_pkg::OCPD_ADDR, rand8());
      bus_write(gbc_mem_pkg::OCPD_ADDR, rand8());
      send_pixel(3'd5, 2'd3, 3'd1, 2'd2, 1'b0);
      send_pixel(3'd5, 2'd3, 3'd1, 2'd2, 1'b1);
      end_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, err_total);
      if (err_total == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("watchdog expired in cycle %0d, the tests did not complete", cyc);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: build.f
logic/gbc_mem_pkg.sv
logic/gbc_video_pkg.sv
logic/io_reg_router.sv
logic/color_file.sv
logic/pixel_color_out.sv
logic/palette_subsystem_top.sv
tb/tb_palette_top.sv

// File: Makefile
.PHONY: run clean

run: obj_dir/Vtb_palette_top
	@out="$$(./obj_dir/Vtb_palette_top)"; echo "$$out"; \
		echo "$$out" | grep -qF '*** PASSED ***'

obj_dir/Vtb_palette_top: build.f $(wildcard logic/*.sv tb/*.sv)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_palette_top \
		-f build.f -o Vtb_palette_top

clean:
	rm -rf obj_dir
